// File: rtl/alloc_pkg.sv
//------------------------------
// shared types and constants for the cell allocator and its self-test
// import with a wildcard in each module header
//------------------------------
package alloc_pkg;

    // tagged memory word and cell index
    typedef logic [15:0] word_t;
    typedef logic [7:0]  cell_idx_t;

    localparam int    HEAP_CELLS = 256;

    // reserved words
    localparam word_t UNDEF      = 16'h0000;
    localparam word_t NIL        = 16'h0001;
    localparam word_t TRUE       = 16'h0002;
    localparam word_t FALSE      = 16'h0003;
    localparam word_t UNIT       = 16'h0004;

    // fixnums carry the top bit
    localparam word_t FIX_ZERO   = 16'h8000;
    // heap address is base OR cell index
    localparam word_t HEAP_BASE  = 16'h5000;

    // one registered request, addresses already reduced to indices
    typedef struct packed {
        logic      alloc;
        word_t     alloc_data;
        logic      free;
        cell_idx_t free_idx;
        logic      wr;
        cell_idx_t wr_idx;
        word_t     wr_data;
        logic      rd;
        cell_idx_t rd_idx;
    } alloc_req_t;

    // script order, the sequencer steps through these one by one
    typedef enum logic [4:0] {
        IDLE_DONE, START,
        W42, W144, R42, GAP0, R144, GAP1, RW, GAP2,
        CONFLICT, CHECK_ERR,
        A0, GAP3, A1, GAP4, A2, GAP5, A3,
        F2, F1, REUSE_A, GAP6, REUSE_B, GAP7, CHECK_LAST, GAP8, GAP9,
        FINISH
    } test_state_t;

endpackage

// File: rtl/alloc_port_check.sv
//------------------------------
// allocator input stage
// registers the request strobes, drops bad ones and flags errors
//------------------------------
`timescale 1ns/1ns

module alloc_port_check import alloc_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_alloc,
    input  word_t      i_alloc_data,
    input  logic       i_free,
    input  word_t      i_free_addr,
    input  logic       i_wr,
    input  word_t      i_waddr,
    input  word_t      i_wdata,
    input  logic       i_rd,
    input  word_t      i_raddr,
    input  logic       i_oom,
    output alloc_req_t o_req,
    output logic       o_err
);

    logic conflict;
    logic bad_free;
    logic bad_wr;
    logic bad_rd;

    function automatic logic in_heap(input word_t addr);
        return addr[15:8] == HEAP_BASE[15:8];
    endfunction

    // alloc shares the write port and the cell, so it excludes wr and rd
    assign conflict = i_alloc && (i_wr || i_rd);
    assign bad_free = i_free && !in_heap(i_free_addr);
    assign bad_wr   = i_wr && !in_heap(i_waddr);
    assign bad_rd   = i_rd && !in_heap(i_raddr);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_req <= '0;
            o_err <= 1'b0;
        end else begin
            o_req.alloc      <= i_alloc && !conflict;
            o_req.alloc_data <= i_alloc_data;
            o_req.free       <= i_free && !bad_free;
            o_req.free_idx   <= cell_idx_t'(i_free_addr[7:0]);
            o_req.wr         <= i_wr && !bad_wr && !conflict;
            o_req.wr_idx     <= cell_idx_t'(i_waddr[7:0]);
            o_req.wr_data    <= i_wdata;
            o_req.rd         <= i_rd && !bad_rd && !conflict;
            o_req.rd_idx     <= cell_idx_t'(i_raddr[7:0]);
            // oom comes from the request already in flight
            o_err            <= conflict || bad_free || bad_wr || bad_rd || i_oom;
        end
    end

endmodule

// File: rtl/alloc_free_list.sv
//------------------------------
// allocator processing stage
// LIFO free list over a link memory, bump pointer for fresh cells
//------------------------------
`timescale 1ns/1ns

module alloc_free_list import alloc_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  alloc_req_t i_req,
    output word_t      o_alloc_addr,
    output cell_idx_t  o_alloc_idx,
    output logic       o_alloc_we,
    output logic       o_oom
);

    // last marks the bottom entry of the list
    typedef struct packed {
        logic      last;
        cell_idx_t next;
    } link_t;

    link_t     link_mem [HEAP_CELLS];
    cell_idx_t head;
    logic      empty;
    cell_idx_t bump;
    logic      bump_done;
    logic      handoff;
    logic      push;
    logic      pop;
    logic      take_bump;
    cell_idx_t pick;

    // free and alloc together hand the freed cell straight over
    assign handoff   = i_req.alloc && i_req.free;
    assign push      = i_req.free && !i_req.alloc;
    assign pop       = i_req.alloc && !i_req.free && !empty;
    assign take_bump = i_req.alloc && !i_req.free && empty && !bump_done;

    assign o_oom      = i_req.alloc && !i_req.free && empty && bump_done;
    assign o_alloc_we = handoff || pop || take_bump;

    always_comb begin
        if (handoff) begin
            pick = i_req.free_idx;
        end else if (!empty) begin
            pick = head;
        end else begin
            pick = bump;
        end
    end

    assign o_alloc_idx = pick;

    always_ff @(posedge i_clk) begin
        if (push) begin
            link_mem[i_req.free_idx] <= '{last: empty, next: head};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            head      <= '0;
            empty     <= 1'b1;
            bump      <= '0;
            bump_done <= 1'b0;
        end else if (push) begin
            head  <= i_req.free_idx;
            empty <= 1'b0;
        end else if (pop) begin
            head  <= link_mem[head].next;
            empty <= link_mem[head].last;
        end else if (take_bump) begin
            bump <= bump + 1'b1;
            // wraps after the last cell
            if (bump == '1) begin
                bump_done <= 1'b1;
            end
        end
    end

    // result register, holds until the next allocation
    always_ff @(posedge i_clk) begin
        if (o_alloc_we) begin
            o_alloc_addr <= HEAP_BASE | {8'h00, pick};
        end
    end

endmodule

// File: rtl/alloc_cell_ram.sv
//------------------------------
// allocator output stage
// cell memory with one write port and a registered read port
//------------------------------
`timescale 1ns/1ns

module alloc_cell_ram import alloc_pkg::*; (
    input  logic       i_clk,
    input  alloc_req_t i_req,
    input  cell_idx_t  i_alloc_idx,
    input  logic       i_alloc_we,
    output word_t      o_rdata
);

    word_t     mem [HEAP_CELLS];
    logic      we;
    cell_idx_t widx;
    word_t     wdata;

    // write and alloc never arrive together
    always_comb begin
        we    = i_req.wr || i_alloc_we;
        widx  = i_req.wr ? i_req.wr_idx : i_alloc_idx;
        wdata = i_req.wr ? i_req.wr_data : i_req.alloc_data;
    end

    always_ff @(posedge i_clk) begin
        if (we) begin
            mem[widx] <= wdata;
        end
    end

    // same-cycle write leaves the old word on the read side
    always_ff @(posedge i_clk) begin
        if (i_req.rd) begin
            o_rdata <= mem[i_req.rd_idx];
        end
    end

endmodule

// File: rtl/alloc_self_test.sv
//------------------------------
// self-test sequencer that runs a fixed script against the allocator
// pauses while i_en is low; o_passed is valid once o_running falls
//------------------------------
`timescale 1ns/1ns

module alloc_self_test import alloc_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_en,
    input  word_t i_rdata,
    input  word_t i_alloc_addr,
    input  logic  i_err,
    output logic  o_alloc,
    output word_t o_alloc_data,
    output logic  o_free,
    output word_t o_free_addr,
    output logic  o_wr,
    output word_t o_waddr,
    output word_t o_wdata,
    output logic  o_rd,
    output word_t o_raddr,
    output logic  o_running,
    output word_t o_debug,
    output logic  o_passed,
    output logic  o_error
);

    test_state_t state;
    logic        err_seen;
    logic        err_now;
    logic        err_clear;
    logic        chk_en;
    word_t       chk_word;
    word_t       chk_exp;

    assign o_running = i_en && (state != IDLE_DONE);

    // keeps an error pulse that lands in a paused cycle
    assign err_now   = i_err || err_seen;
    assign err_clear = o_running && (state == CHECK_ERR);

    // request strobes of the current step
    always_comb begin
        o_alloc      = 1'b0;
        o_alloc_data = UNDEF;
        o_free       = 1'b0;
        o_free_addr  = UNDEF;
        o_wr         = 1'b0;
        o_waddr      = UNDEF;
        o_wdata      = UNDEF;
        o_rd         = 1'b0;
        o_raddr      = UNDEF;
        if (o_running) begin
            case (state)
                W42: begin
                    o_wr    = 1'b1;
                    o_waddr = HEAP_BASE | 16'd42;
                    o_wdata = FIX_ZERO | 16'd420;
                end
                W144: begin
                    o_wr    = 1'b1;
                    o_waddr = HEAP_BASE | 16'd144;
                    o_wdata = FIX_ZERO | 16'd1337;
                end
                R42: begin
                    o_rd    = 1'b1;
                    o_raddr = HEAP_BASE | 16'd42;
                end
                R144: begin
                    o_rd    = 1'b1;
                    o_raddr = HEAP_BASE | 16'd144;
                end
                // overwrite the cell being read, the read must see the old word
                RW: begin
                    o_rd    = 1'b1;
                    o_raddr = HEAP_BASE | 16'd42;
                    o_wr    = 1'b1;
                    o_waddr = HEAP_BASE | 16'd42;
                    o_wdata = UNIT;
                end
                // read and alloc together must be refused
                CONFLICT: begin
                    o_rd         = 1'b1;
                    o_raddr      = HEAP_BASE | 16'd13;
                    o_alloc      = 1'b1;
                    o_alloc_data = NIL;
                end
                A0: begin
                    o_alloc      = 1'b1;
                    o_alloc_data = FIX_ZERO | 16'd256;
                end
                A1: begin
                    o_alloc      = 1'b1;
                    o_alloc_data = FIX_ZERO | 16'd257;
                end
                A2: begin
                    o_alloc      = 1'b1;
                    o_alloc_data = FIX_ZERO | 16'd258;
                end
                F2: begin
                    o_free      = 1'b1;
                    o_free_addr = HEAP_BASE | 16'd2;
                end
                F1: begin
                    o_free      = 1'b1;
                    o_free_addr = HEAP_BASE | 16'd1;
                end
                REUSE_A: begin
                    o_alloc      = 1'b1;
                    o_alloc_data = FIX_ZERO | 16'd259;
                end
                REUSE_B: begin
                    o_free       = 1'b1;
                    o_free_addr  = HEAP_BASE | 16'd0;
                    o_alloc      = 1'b1;
                    o_alloc_data = TRUE;
                end
                CHECK_LAST: begin
                    o_alloc      = 1'b1;
                    o_alloc_data = FIX_ZERO | 16'd261;
                end
                default: ;
            endcase
        end
    end

    // expected result of the step issued two steps earlier
    always_comb begin
        chk_en   = 1'b1;
        chk_word = i_alloc_addr;
        chk_exp  = UNDEF;
        case (state)
            R144: begin
                chk_word = i_rdata;
                chk_exp  = FIX_ZERO | 16'd420;
            end
            RW: begin
                chk_word = i_rdata;
                chk_exp  = FIX_ZERO | 16'd1337;
            end
            CONFLICT: begin
                chk_word = i_rdata;
                chk_exp  = FIX_ZERO | 16'd420;
            end
            A1:         chk_exp = HEAP_BASE | 16'd0;
            A2:         chk_exp = HEAP_BASE | 16'd1;
            A3:         chk_exp = HEAP_BASE | 16'd2;
            // LIFO order after freeing 2 then 1
            REUSE_B:    chk_exp = HEAP_BASE | 16'd1;
            CHECK_LAST: chk_exp = HEAP_BASE | 16'd0;
            FINISH:     chk_exp = HEAP_BASE | 16'd2;
            default:    chk_en = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= START;
            o_debug  <= UNDEF;
            o_passed <= 1'b0;
            o_error  <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            err_seen <= (err_seen || i_err) && !err_clear;
            if (o_running) begin
                if (state == CHECK_ERR && !err_now) begin
                    // expected conflict error never came
                    o_debug <= FALSE;
                    state   <= IDLE_DONE;
                end else if (state != CHECK_ERR && err_now) begin
                    o_error <= 1'b1;
                    state   <= IDLE_DONE;
                end else if (chk_en && chk_word != chk_exp) begin
                    o_debug <= chk_word;
                    state   <= IDLE_DONE;
                end else if (state == FINISH) begin
                    o_passed <= 1'b1;
                    state    <= IDLE_DONE;
                end else begin
                    state <= test_state_t'(state + 5'd1);
                end
            end
        end
    end

endmodule

// File: rtl/alloc_bist_top.sv
//------------------------------
// allocator with its self-test sequencer
// hold i_en high to run, read o_passed after o_running falls
//------------------------------
`timescale 1ns/1ns

module alloc_bist_top import alloc_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_en,
    output logic  o_running,
    output word_t o_debug,
    output logic  o_passed,
    output logic  o_error
);

    // raw requests from the sequencer
    logic       alloc;
    word_t      alloc_data;
    logic       free;
    word_t      free_addr;
    logic       wr;
    word_t      waddr;
    word_t      wdata;
    logic       rd;
    word_t      raddr;

    // allocator internals and results
    alloc_req_t req;
    logic       err;
    logic       oom;
    word_t      alloc_addr;
    cell_idx_t  alloc_idx;
    logic       alloc_we;
    word_t      rdata;

    alloc_self_test u_self_test (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(i_en),
        .i_rdata(rdata), .i_alloc_addr(alloc_addr), .i_err(err),
        .o_alloc(alloc), .o_alloc_data(alloc_data),
        .o_free(free), .o_free_addr(free_addr),
        .o_wr(wr), .o_waddr(waddr), .o_wdata(wdata),
        .o_rd(rd), .o_raddr(raddr),
        .o_running(o_running), .o_debug(o_debug),
        .o_passed(o_passed), .o_error(o_error)
    );

    alloc_port_check u_port_check (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_alloc(alloc), .i_alloc_data(alloc_data),
        .i_free(free), .i_free_addr(free_addr),
        .i_wr(wr), .i_waddr(waddr), .i_wdata(wdata),
        .i_rd(rd), .i_raddr(raddr),
        .i_oom(oom), .o_req(req), .o_err(err)
    );

    alloc_free_list u_free_list (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(req),
        .o_alloc_addr(alloc_addr), .o_alloc_idx(alloc_idx),
        .o_alloc_we(alloc_we), .o_oom(oom)
    );

    alloc_cell_ram u_cell_ram (
        .i_clk(i_clk), .i_req(req),
        .i_alloc_idx(alloc_idx), .i_alloc_we(alloc_we),
        .o_rdata(rdata)
    );

endmodule

// File: test/alloc_bist_assertions.sv
//------------------------------
// concurrent checks on the self-test ports
// bound into alloc_bist_top, a failing property raises $error
//------------------------------
`timescale 1ns/1ns

module alloc_bist_assertions import alloc_pkg::*; (
    input logic  i_clk,
    input logic  i_rst,
    input logic  i_en,
    input logic  i_running,
    input word_t i_debug,
    input logic  i_passed,
    input logic  i_error
);

    // one flag per property, the testbench watches their union
    logic gate_failed  = 1'b0;
    logic hold_failed  = 1'b0;
    logic both_failed  = 1'b0;
    logic fall_failed  = 1'b0;
    logic clear_failed = 1'b0;
    logic done_failed  = 1'b0;
    logic any_failed;

    assign any_failed = gate_failed || hold_failed || both_failed
                     || fall_failed || clear_failed || done_failed;

    // sequencer only steps while enabled
    a_gate: assert property (@(posedge i_clk) disable iff (i_rst) !i_en |-> !i_running)
        else begin
            gate_failed = 1'b1;
            $error("o_running high while i_en is low");
        end

    // a paused cycle leaves every result output alone
    a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_en |=> $stable(i_debug) && $stable(i_passed) && $stable(i_error))
        else begin
            hold_failed = 1'b1;
            $error("result outputs changed while i_en was low");
        end

    a_both: assert property (@(posedge i_clk) !(i_passed && i_error))
        else begin
            both_failed = 1'b1;
            $error("o_passed and o_error high together");
        end

    // only reset may take back a pass
    a_fall: assert property (@(posedge i_clk) $fell(i_passed) |-> $past(i_rst))
        else begin
            fall_failed = 1'b1;
            $error("o_passed fell without a reset");
        end

    a_clear: assert property (@(posedge i_clk)
        i_rst |=> !i_passed && !i_error && i_debug == UNDEF)
        else begin
            clear_failed = 1'b1;
            $error("reset did not clear the result outputs");
        end

    // script is over once it passed
    a_done: assert property (@(posedge i_clk) disable iff (i_rst) i_passed |-> !i_running)
        else begin
            done_failed = 1'b1;
            $error("o_running high after the script passed");
        end

endmodule

bind alloc_bist_top alloc_bist_assertions u_assertions (
    .i_clk(i_clk), .i_rst(i_rst), .i_en(i_en), .i_running(o_running),
    .i_debug(o_debug), .i_passed(o_passed), .i_error(o_error)
);

// File: test/alloc_bist_tb.sv
//------------------------------
// testbench for the allocator self-test subsystem
// runs the script with steady, random and interrupted enables
//------------------------------
`timescale 1ns/1ns

module alloc_bist_tb import alloc_pkg::*; ();

    localparam int SCRIPT_CYCLES  = 28;
    localparam int RESET_CYCLES   = 4;
    localparam int IDLE_CYCLES    = 6;
    localparam int PARTIAL_CYCLES = 10;
    localparam int MARGIN_CYCLES  = 50;
    // paused cycles come on top of this
    localparam int BUDGET_CYCLES  = 4 * RESET_CYCLES + 3 * SCRIPT_CYCLES
                                  + PARTIAL_CYCLES + MARGIN_CYCLES;

    logic  clk;
    logic  rst;
    logic  en;
    logic  running;
    word_t debug;
    logic  passed;
    logic  error;

    alloc_bist_top DUT (
        .i_clk(clk), .i_rst(rst), .i_en(en),
        .o_running(running), .o_debug(debug), .o_passed(passed), .o_error(error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else
            stop_with_failure($sformatf("Mismatch %s: got 0x%04h, expected 0x%04h",
                                        name, got, exp));
    endtask

    task automatic check_outcome();
        check_value("o_passed", word_t'(passed), 16'h0001);
        check_value("o_error", word_t'(error), 16'h0000);
        check_value("o_debug", debug, UNDEF);
    endtask

    // called just after a rising edge, returns on the edge that releases reset
    task automatic apply_reset();
        rst <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("o_passed", word_t'(passed), 16'h0000);
        check_value("o_error", word_t'(error), 16'h0000);
        check_value("o_debug", debug, UNDEF);
        @(posedge clk);
        rst <= 1'b0;
    endtask

    // counts sequencer steps until it stops while enabled
    task automatic run_script(input bit random_en, output int steps);
        steps = 0;
        forever begin
            @(negedge clk);
            if (running) begin
                steps++;
            end else if (en) begin
                break;
            end
            @(posedge clk);
            en <= random_en ? (($urandom % 4) != 0) : 1'b1;
        end
    endtask

    initial begin : watchdog
        int cycles;
        int paused;
        cycles = 0;
        paused = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (!en) begin
                paused++;
            end
            if (cycles > BUDGET_CYCLES + paused) begin
                stop_with_failure($sformatf("timeout, no end after %0d cycles", cycles));
            end
        end
    end

    // failures of the bound checker end the run here
    always @(negedge clk) begin
        assert (!DUT.u_assertions.any_failed) else
            stop_with_failure("a concurrent assertion on the DUT ports failed");
    end

    initial begin : main
        int steps;
        rst = 1'b1;
        en  = 1'b0;
        void'($urandom(32'h33e0));

        // steady enable
        @(posedge clk);
        en <= 1'b1;
        apply_reset();
        run_script(1'b0, steps);
        check_value("o_running steps", word_t'(steps), word_t'(SCRIPT_CYCLES));
        check_outcome();

        // disabled after the end, results hold
        @(posedge clk);
        en <= 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk);
        check_value("o_running", word_t'(running), 16'h0000);
        check_outcome();

        // random pauses through the whole script
        @(posedge clk);
        en <= 1'b1;
        apply_reset();
        run_script(1'b1, steps);
        check_value("o_running steps", word_t'(steps), word_t'(SCRIPT_CYCLES));
        check_outcome();

        // reset part way through, then a clean second run
        @(posedge clk);
        en <= 1'b1;
        apply_reset();
        repeat (PARTIAL_CYCLES) @(negedge clk);
        check_value("o_running", word_t'(running), 16'h0001);
        @(posedge clk);
        apply_reset();
        run_script(1'b0, steps);
        check_value("o_running steps", word_t'(steps), word_t'(SCRIPT_CYCLES));
        check_outcome();

        @(negedge clk);
        if (DUT.u_assertions.any_failed) begin
            stop_with_failure("a concurrent assertion failed in the last cycle");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: build.f
rtl/alloc_pkg.sv
rtl/alloc_port_check.sv
rtl/alloc_free_list.sv
rtl/alloc_cell_ram.sv
rtl/alloc_self_test.sv
rtl/alloc_bist_top.sv
test/alloc_bist_assertions.sv
test/alloc_bist_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile the allocator self-test with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module alloc_bist_tb -f build.f

# let the testbench end the run after a checker error
output=$(./obj_dir/Valloc_bist_tb +verilator+error+limit+100 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
